//--- design/dcache_geom_pkg.sv
`default_nettype none

package dcache_geom_pkg;

    // bus widths seen by consumers and memory
    localparam int ADDR_BITS = 8;
    localparam int DATA_BITS = 8;
    localparam int NUM_CONSUMERS = 4;

    // address layout is tag | index | offset
    localparam int OFFSET_BITS = 1;
    localparam int INDEX_BITS = 4;
    localparam int TAG_BITS = ADDR_BITS - INDEX_BITS - OFFSET_BITS;

    // direct mapped, one line per index
    localparam int WORDS_PER_LINE = 2 ** OFFSET_BITS;
    localparam int NUM_LINES = 2 ** INDEX_BITS;

    typedef logic [ADDR_BITS-1:0] addr_t;
    typedef logic [DATA_BITS-1:0] word_t;
    typedef logic [TAG_BITS-1:0] tag_t;
    typedef logic [INDEX_BITS-1:0] index_t;
    typedef logic [$clog2(NUM_CONSUMERS)-1:0] consumer_id_t;

    // word 0 sits in the low byte, matches the even address
    typedef logic [WORDS_PER_LINE-1:0][DATA_BITS-1:0] line_t;

    // field extraction, shared by lookup and fill logic
    function automatic tag_t addr_tag(input addr_t addr);
        return addr[ADDR_BITS-1 -: TAG_BITS];
    endfunction

    function automatic index_t addr_index(input addr_t addr);
        return addr[OFFSET_BITS +: INDEX_BITS];
    endfunction

    function automatic logic [OFFSET_BITS-1:0] addr_offset(input addr_t addr);
        return addr[OFFSET_BITS-1:0];
    endfunction

endpackage

`default_nettype wire

//--- design/dcache_ctrl_pkg.sv
`default_nettype none

package dcache_ctrl_pkg;
    import dcache_geom_pkg::*;

    typedef enum logic {
        OP_READ,
        OP_WRITE
    } cache_op_e;

    // memory side sequencing, one transaction at a time
    typedef enum logic [2:0] {
        SEQ_IDLE,
        SEQ_FILL_LO,
        SEQ_FILL_HI,
        SEQ_WRITE,
        SEQ_RESPOND
    } seq_state_e;

    // request picked by the arbiter, valid is a one cycle pulse
    typedef struct packed {
        logic         valid;
        cache_op_e    op;
        consumer_id_t id;
        addr_t        addr;
        word_t        wdata;
    } cache_req_t;

    // request with its lookup result and the line as stored before any update
    typedef struct packed {
        cache_req_t req;
        logic       hit;
        line_t      line;
    } lookup_t;

    // completed line from a miss, written into the arrays
    typedef struct packed {
        logic   valid;
        index_t index;
        tag_t   tag;
        line_t  line;
    } fill_t;

    // final answer handed to the relay
    typedef struct packed {
        logic         valid;
        cache_op_e    op;
        consumer_id_t id;
        word_t        rdata;
    } cache_rsp_t;

endpackage

`default_nettype wire

//--- design/consumer_arbiter.sv
`default_nettype none
`timescale 1ns/1ps

module consumer_arbiter
    import dcache_geom_pkg::*, dcache_ctrl_pkg::*;
(
    input  logic                     clk,
    input  logic                     reset,
    input  logic [NUM_CONSUMERS-1:0] read_valid,
    input  logic [NUM_CONSUMERS-1:0] write_valid,
    input  addr_t                    read_address [NUM_CONSUMERS],
    input  addr_t                    write_address [NUM_CONSUMERS],
    input  word_t                    write_data [NUM_CONSUMERS],
    input  logic                     done,
    output cache_req_t               req
);

    // high from a pick until the relay reports the consumer released
    logic busy;

    // result of the priority scan
    logic         pick_found;
    consumer_id_t pick_id;
    cache_op_e    pick_op;

    // scan from the top down so the lowest index wins last
    always_comb begin
        pick_found = 1'b0;
        pick_id = '0;
        pick_op = OP_READ;
        for (int i = NUM_CONSUMERS - 1; i >= 0; i--) begin
            if (read_valid[i] || write_valid[i]) begin
                pick_found = 1'b1;
                pick_id = consumer_id_t'(i);
                // a read beats a write from the same consumer
                pick_op = read_valid[i] ? OP_READ : OP_WRITE;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            busy <= 1'b0;
            req.valid <= 1'b0;
        end else begin
            // request leaves as a single pulse
            req.valid <= 1'b0;
            if (!busy && pick_found) begin
                busy <= 1'b1;
                req.valid <= 1'b1;
                req.op <= pick_op;
                req.id <= pick_id;
                // address comes from the port that matches the op
                if (pick_op == OP_READ) begin
                    req.addr <= read_address[pick_id];
                end else begin
                    req.addr <= write_address[pick_id];
                end
                // ignored downstream on reads
                req.wdata <= write_data[pick_id];
            end else if (done) begin
                // consumer dropped valid, free for the next pick
                busy <= 1'b0;
            end
        end
    end

endmodule

`default_nettype wire

//--- design/cache_store.sv
`default_nettype none
`timescale 1ns/1ps

module cache_store
    import dcache_geom_pkg::*, dcache_ctrl_pkg::*;
(
    input  logic       clk,
    input  logic       reset,
    input  cache_req_t req,
    input  fill_t      fill,
    output lookup_t    lookup
);

    // per line state
    logic [NUM_LINES-1:0] line_valid;
    tag_t                 tag_arr [NUM_LINES];
    line_t                data_arr [NUM_LINES];

    // request address split
    tag_t                   req_tag;
    index_t                 req_index;
    logic [OFFSET_BITS-1:0] req_offset;
    logic                   req_hit;

    assign req_tag = addr_tag(req.addr);
    assign req_index = addr_index(req.addr);
    assign req_offset = addr_offset(req.addr);

    // hit needs a valid line and a matching tag
    assign req_hit = line_valid[req_index] && (tag_arr[req_index] == req_tag);

    // lookup result and valid bits
    always_ff @(posedge clk) begin
        if (reset) begin
            line_valid <= '0;
            lookup.req.valid <= 1'b0;
        end else begin
            // lookup follows the request by one cycle
            lookup.req <= req;
            lookup.hit <= req_hit;
            lookup.line <= data_arr[req_index];
            // fill from a miss marks the line usable
            if (fill.valid) begin
                line_valid[fill.index] <= 1'b1;
            end
        end
    end

    // tag and data arrays
    always_ff @(posedge clk) begin
        // write-through, keep a cached copy current on a write hit
        if (req.valid && req.op == OP_WRITE && req_hit) begin
            data_arr[req_index][req_offset] <= req.wdata;
        end
        // miss refill, replaces whatever line sat at this index
        if (fill.valid) begin
            data_arr[fill.index] <= fill.line;
            tag_arr[fill.index] <= fill.tag;
        end
    end

endmodule

`default_nettype wire

//--- design/mem_sequencer.sv
`default_nettype none
`timescale 1ns/1ps

module mem_sequencer
    import dcache_geom_pkg::*, dcache_ctrl_pkg::*;
(
    input  logic       clk,
    input  logic       reset,
    input  lookup_t    lookup,
    input  logic       mem_read_ready,
    input  logic       mem_write_ready,
    input  word_t      mem_read_data,
    output logic       mem_read_valid,
    output logic       mem_write_valid,
    output addr_t      mem_read_address,
    output addr_t      mem_write_address,
    output word_t      mem_write_data,
    output fill_t      fill,
    output cache_rsp_t rsp
);

    seq_state_e state;

    // request held for the whole transaction
    cache_req_t req_q;
    // line from the lookup, or assembled from memory on a miss
    line_t      line_q;
    logic       fill_valid;

    // even word first, odd word in the second fill phase
    assign mem_read_address = {addr_tag(req_q.addr), addr_index(req_q.addr),
                               state == SEQ_FILL_HI};

    // write valid holds for as long as the FSM waits on it
    assign mem_write_valid = (state == SEQ_WRITE);
    assign mem_write_address = req_q.addr;
    assign mem_write_data = req_q.wdata;

    always_comb begin
        fill.valid = fill_valid;
        fill.index = addr_index(req_q.addr);
        fill.tag = addr_tag(req_q.addr);
        fill.line = line_q;
    end

    // response lasts exactly the one cycle spent in SEQ_RESPOND
    always_comb begin
        rsp.valid = (state == SEQ_RESPOND);
        rsp.op = req_q.op;
        rsp.id = req_q.id;
        rsp.rdata = line_q[addr_offset(req_q.addr)];
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            state <= SEQ_IDLE;
            mem_read_valid <= 1'b0;
            fill_valid <= 1'b0;
        end else begin
            fill_valid <= 1'b0;
            case (state)
                SEQ_IDLE: begin
                    if (lookup.req.valid) begin
                        req_q <= lookup.req;
                        line_q <= lookup.line;
                        if (lookup.req.op == OP_WRITE) begin
                            // every write goes out, hit or miss
                            state <= SEQ_WRITE;
                        end else if (lookup.hit) begin
                            state <= SEQ_RESPOND;
                        end else begin
                            // miss starts with the even word
                            state <= SEQ_FILL_LO;
                            mem_read_valid <= 1'b1;
                        end
                    end
                end
                SEQ_FILL_LO: begin
                    if (mem_read_valid && mem_read_ready) begin
                        line_q[0] <= mem_read_data;
                        // drop valid for a cycle between the two reads
                        mem_read_valid <= 1'b0;
                        state <= SEQ_FILL_HI;
                    end
                end
                SEQ_FILL_HI: begin
                    if (mem_read_valid && mem_read_ready) begin
                        line_q[1] <= mem_read_data;
                        mem_read_valid <= 1'b0;
                        // line complete, cache takes it during SEQ_RESPOND
                        fill_valid <= 1'b1;
                        state <= SEQ_RESPOND;
                    end else if (!mem_read_valid) begin
                        mem_read_valid <= 1'b1;
                    end
                end
                SEQ_WRITE: begin
                    if (mem_write_ready) begin
                        state <= SEQ_RESPOND;
                    end
                end
                SEQ_RESPOND: begin
                    state <= SEQ_IDLE;
                end
                default: begin
                    state <= SEQ_IDLE;
                end
            endcase
        end
    end

endmodule

`default_nettype wire

//--- design/consumer_relay.sv
`default_nettype none
`timescale 1ns/1ps

module consumer_relay
    import dcache_geom_pkg::*, dcache_ctrl_pkg::*;
(
    input  logic                     clk,
    input  logic                     reset,
    input  cache_rsp_t               rsp,
    input  logic [NUM_CONSUMERS-1:0] read_valid,
    input  logic [NUM_CONSUMERS-1:0] write_valid,
    output logic [NUM_CONSUMERS-1:0] read_ready,
    output logic [NUM_CONSUMERS-1:0] write_ready,
    output word_t                    read_data [NUM_CONSUMERS],
    output logic                     done
);

    // set while a consumer holds its ready
    logic         active;
    consumer_id_t id_q;
    cache_op_e    op_q;
    // the one valid that matters for the transaction in progress
    logic         held_valid;

    assign held_valid = (op_q == OP_READ) ? read_valid[id_q] : write_valid[id_q];

    always_ff @(posedge clk) begin
        if (reset) begin
            active <= 1'b0;
            read_ready <= '0;
            write_ready <= '0;
            done <= 1'b0;
        end else begin
            done <= 1'b0;
            if (rsp.valid) begin
                active <= 1'b1;
                id_q <= rsp.id;
                op_q <= rsp.op;
                if (rsp.op == OP_READ) begin
                    read_ready[rsp.id] <= 1'b1;
                    read_data[rsp.id] <= rsp.rdata;
                end else begin
                    write_ready[rsp.id] <= 1'b1;
                end
            end else if (active && !held_valid) begin
                // consumer let go, release ready and free the arbiter
                active <= 1'b0;
                read_ready <= '0;
                write_ready <= '0;
                done <= 1'b1;
            end
        end
    end

endmodule

`default_nettype wire

//--- design/dmem_cache.sv
`default_nettype none
`timescale 1ns/1ps

module dmem_cache
    import dcache_geom_pkg::*, dcache_ctrl_pkg::*;
(
    input  logic                     clk,
    input  logic                     reset,
    // consumer side
    input  logic [NUM_CONSUMERS-1:0] read_valid,
    input  addr_t                    read_address [NUM_CONSUMERS],
    output logic [NUM_CONSUMERS-1:0] read_ready,
    output word_t                    read_data [NUM_CONSUMERS],
    input  logic [NUM_CONSUMERS-1:0] write_valid,
    input  addr_t                    write_address [NUM_CONSUMERS],
    input  word_t                    write_data [NUM_CONSUMERS],
    output logic [NUM_CONSUMERS-1:0] write_ready,
    // external memory, single channel
    output logic                     mem_read_valid,
    output addr_t                    mem_read_address,
    input  logic                     mem_read_ready,
    input  word_t                    mem_read_data,
    output logic                     mem_write_valid,
    output addr_t                    mem_write_address,
    output word_t                    mem_write_data,
    input  logic                     mem_write_ready
);

    cache_req_t req;
    lookup_t    lookup;
    fill_t      fill;
    cache_rsp_t rsp;
    // relay back to arbiter, closes the transaction
    logic       done;

    consumer_arbiter u_arbiter (
        .clk           (clk),
        .reset         (reset),
        .read_valid    (read_valid),
        .write_valid   (write_valid),
        .read_address  (read_address),
        .write_address (write_address),
        .write_data    (write_data),
        .done          (done),
        .req           (req)
    );

    cache_store u_store (
        .clk    (clk),
        .reset  (reset),
        .req    (req),
        .fill   (fill),
        .lookup (lookup)
    );

    mem_sequencer u_sequencer (
        .clk               (clk),
        .reset             (reset),
        .lookup            (lookup),
        .mem_read_ready    (mem_read_ready),
        .mem_write_ready   (mem_write_ready),
        .mem_read_data     (mem_read_data),
        .mem_read_valid    (mem_read_valid),
        .mem_write_valid   (mem_write_valid),
        .mem_read_address  (mem_read_address),
        .mem_write_address (mem_write_address),
        .mem_write_data    (mem_write_data),
        .fill              (fill),
        .rsp               (rsp)
    );

    consumer_relay u_relay (
        .clk         (clk),
        .reset       (reset),
        .rsp         (rsp),
        .read_valid  (read_valid),
        .write_valid (write_valid),
        .read_ready  (read_ready),
        .write_ready (write_ready),
        .read_data   (read_data),
        .done        (done)
    );

endmodule

`default_nettype wire

//--- verif/tb_clock_gen.sv
`default_nettype none
`timescale 1ns/1ps

module tb_clock_gen (
    output logic clk,
    output logic reset
);

    // 40 ns period, 20 ns per phase
    initial begin
        clk = 1'b0;
        forever begin
            #20 clk = ~clk;
        end
    end

    // reset held over 16 rising edges, released on a falling edge
    initial begin
        reset = 1'b1;
        repeat (16) @(posedge clk);
        @(negedge clk);
        reset = 1'b0;
    end

endmodule

`default_nettype wire

//--- verif/dmem_cache_asserts.sv
`default_nettype none
`timescale 1ns/1ps

module dmem_cache_asserts
    import dcache_geom_pkg::*;
(
    input logic                     clk,
    input logic                     reset,
    input logic                     mem_read_valid,
    input logic                     mem_read_ready,
    input addr_t                    mem_read_address,
    input logic                     mem_write_valid,
    input logic [NUM_CONSUMERS-1:0] read_ready,
    input logic [NUM_CONSUMERS-1:0] write_ready
);

    // single memory channel, one direction at a time
    assert property (@(posedge clk) disable iff (reset)
        !(mem_read_valid && mem_write_valid))
        else $error("memory read and write valid high together");

    // only the consumer being served may see ready
    assert property (@(posedge clk) disable iff (reset)
        $onehot0({read_ready, write_ready}))
        else $error("more than one consumer ready bit high");

    // read request stays up, same address, until memory acks it
    assert property (@(posedge clk) disable iff (reset)
        (mem_read_valid && !mem_read_ready) |=>
            (mem_read_valid && $stable(mem_read_address)))
        else $error("memory read request dropped or moved before ready");

endmodule

bind dmem_cache dmem_cache_asserts u_asserts (
    .clk              (clk),
    .reset            (reset),
    .mem_read_valid   (mem_read_valid),
    .mem_read_ready   (mem_read_ready),
    .mem_read_address (mem_read_address),
    .mem_write_valid  (mem_write_valid),
    .read_ready       (read_ready),
    .write_ready      (write_ready)
);

`default_nettype wire

//--- verif/dmem_cache_tb.sv
`default_nettype none
`timescale 1ns/1ps

module dmem_cache_tb
    import dcache_geom_pkg::*, dcache_ctrl_pkg::*;
();

    localparam int TIMEOUT_CYCLES = 200;

    // one request of the stimulus table
    typedef struct packed {
        consumer_id_t consumer;
        cache_op_e    op;
        addr_t        addr;
        word_t        wdata;
        word_t        exp_rdata;
        int           exp_reads;
    } row_t;

    logic                     clk;
    logic                     reset;
    logic [NUM_CONSUMERS-1:0] read_valid;
    addr_t                    read_address [NUM_CONSUMERS];
    logic [NUM_CONSUMERS-1:0] read_ready;
    word_t                    read_data [NUM_CONSUMERS];
    logic [NUM_CONSUMERS-1:0] write_valid;
    addr_t                    write_address [NUM_CONSUMERS];
    word_t                    write_data [NUM_CONSUMERS];
    logic [NUM_CONSUMERS-1:0] write_ready;
    logic                     mem_read_valid;
    addr_t                    mem_read_address;
    logic                     mem_read_ready;
    word_t                    mem_read_data;
    logic                     mem_write_valid;
    addr_t                    mem_write_address;
    word_t                    mem_write_data;
    logic                     mem_write_ready;

    // memory model state
    word_t mem [256];
    int    seed = 32'hf170_aff2;
    int    rd_wait;
    int    wr_wait;
    int    mem_reads;
    int    mem_writes;
    addr_t rd_log [$];
    addr_t last_wr_addr;
    word_t last_wr_data;

    // expected side, mirrors every write
    word_t ref_mem [256];
    row_t  rows [$];
    int    errors;
    int    tests;
    int    failed_tests;

    tb_clock_gen u_clock_gen (
        .clk   (clk),
        .reset (reset)
    );

    // all port names match the DUT
    dmem_cache DUT (.*);

    // memory answers each strobe after 1 to 4 cycles, ready is a one cycle pulse
    initial begin
        mem_read_ready = 1'b0;
        mem_read_data = '0;
        mem_write_ready = 1'b0;
        rd_wait = 0;
        wr_wait = 0;
        mem_reads = 0;
        mem_writes = 0;
        for (int a = 0; a < 256; a++) begin
            mem[a] = word_t'(a) ^ 8'h5a;
        end
        forever begin
            @(negedge clk);
            if (mem_read_ready) begin
                mem_read_ready = 1'b0;
            end else if (mem_read_valid) begin
                if (rd_wait == 0) begin
                    rd_wait = 1 + ({$random(seed)} % 4);
                end
                rd_wait--;
                if (rd_wait == 0) begin
                    mem_read_ready = 1'b1;
                    mem_read_data = mem[mem_read_address];
                    rd_log.push_back(mem_read_address);
                    mem_reads++;
                end
            end
            if (mem_write_ready) begin
                mem_write_ready = 1'b0;
            end else if (mem_write_valid) begin
                if (wr_wait == 0) begin
                    wr_wait = 1 + ({$random(seed)} % 4);
                end
                wr_wait--;
                if (wr_wait == 0) begin
                    mem_write_ready = 1'b1;
                    mem[mem_write_address] = mem_write_data;
                    last_wr_addr = mem_write_address;
                    last_wr_data = mem_write_data;
                    mem_writes++;
                end
            end
        end
    end

    function automatic logic ready_of(input consumer_id_t c, input cache_op_e op);
        return (op == OP_READ) ? read_ready[c] : write_ready[c];
    endfunction

    task automatic report_value(input string name, input logic [31:0] got,
                                input logic [31:0] expected);
        $display("Error at %0t ns: %s got %0h, expected %0h", $time, name, got, expected);
        errors++;
    endtask

    // polls on falling edges until the ready bit reaches level
    task automatic wait_ready(input consumer_id_t c, input cache_op_e op, input logic level);
        int cnt;
        cnt = 0;
        while (ready_of(c, op) !== level && cnt < TIMEOUT_CYCLES) begin
            @(negedge clk);
            cnt++;
        end
        if (ready_of(c, op) !== level) begin
            $display("timeout: consumer %0d %s ready never went to %b", c, op.name(), level);
            errors++;
        end
    endtask

    // expected read word taken from the mirror before this row's own write
    task automatic add_row(input consumer_id_t c, input cache_op_e op, input addr_t a,
                           input word_t d, input int reads);
        row_t r;
        r.consumer = c;
        r.op = op;
        r.addr = a;
        r.wdata = d;
        r.exp_reads = reads;
        r.exp_rdata = ref_mem[a];
        if (op == OP_WRITE) begin
            ref_mem[a] = d;
        end
        rows.push_back(r);
    endtask

    task automatic end_test(input string label, input int start_errors);
        tests++;
        if (errors == start_errors) begin
            $display("test %0d %s: ok", tests, label);
        end else begin
            failed_tests++;
            $display("test %0d %s: FAILED", tests, label);
        end
    endtask

    task automatic run_row(input row_t r);
        int        base_reads;
        int        base_writes;
        int        start_errors;
        cache_op_e op;
        consumer_id_t c;
        op = r.op;
        c = r.consumer;
        base_reads = mem_reads;
        base_writes = mem_writes;
        start_errors = errors;
        @(negedge clk);
        if (op == OP_READ) begin
            read_address[c] = r.addr;
            read_valid[c] = 1'b1;
        end else begin
            write_address[c] = r.addr;
            write_data[c] = r.wdata;
            write_valid[c] = 1'b1;
        end
        wait_ready(c, op, 1'b1);
        if (op == OP_READ && read_data[c] !== r.exp_rdata) begin
            report_value("read_data", 32'(read_data[c]), 32'(r.exp_rdata));
        end
        if (mem_reads - base_reads != r.exp_reads) begin
            report_value("mem_read strobes", mem_reads - base_reads, r.exp_reads);
        end
        // a fill fetches the even word, then the odd one
        if (mem_reads - base_reads == 2) begin
            if (rd_log[base_reads] !== {r.addr[ADDR_BITS-1:1], 1'b0}) begin
                report_value("mem_read_address", 32'(rd_log[base_reads]),
                             32'({r.addr[ADDR_BITS-1:1], 1'b0}));
            end
            if (rd_log[base_reads+1] !== {r.addr[ADDR_BITS-1:1], 1'b1}) begin
                report_value("mem_read_address", 32'(rd_log[base_reads+1]),
                             32'({r.addr[ADDR_BITS-1:1], 1'b1}));
            end
        end
        // write-through, exactly one memory write per store
        if (mem_writes - base_writes != ((op == OP_WRITE) ? 1 : 0)) begin
            report_value("mem_write strobes", mem_writes - base_writes,
                         (op == OP_WRITE) ? 1 : 0);
        end else if (op == OP_WRITE) begin
            if (last_wr_addr !== r.addr) begin
                report_value("mem_write_address", 32'(last_wr_addr), 32'(r.addr));
            end
            if (last_wr_data !== r.wdata) begin
                report_value("mem_write_data", 32'(last_wr_data), 32'(r.wdata));
            end
        end
        read_valid[c] = 1'b0;
        write_valid[c] = 1'b0;
        wait_ready(c, op, 1'b0);
        end_test($sformatf("consumer %0d %s addr %h", c, op.name(), r.addr), start_errors);
    endtask

    // both consumers raise valid on the same edge, lower index goes first
    task automatic serve_pair(input consumer_id_t lo, input addr_t lo_addr,
                              input consumer_id_t hi, input addr_t hi_addr);
        int base_reads;
        int start_errors;
        base_reads = mem_reads;
        start_errors = errors;
        @(negedge clk);
        read_address[lo] = lo_addr;
        read_address[hi] = hi_addr;
        read_valid[lo] = 1'b1;
        read_valid[hi] = 1'b1;
        wait_ready(lo, OP_READ, 1'b1);
        if (read_ready[hi] !== 1'b0) begin
            $display("consumer %0d got ready while consumer %0d was served", hi, lo);
            errors++;
        end
        if (read_data[lo] !== ref_mem[lo_addr]) begin
            report_value("read_data", 32'(read_data[lo]), 32'(ref_mem[lo_addr]));
        end
        // ready must stay up while the consumer keeps valid
        repeat (3) begin
            @(negedge clk);
            if (read_ready[lo] !== 1'b1 || read_ready[hi] !== 1'b0) begin
                $display("ready changed while consumer %0d still held valid", lo);
                errors++;
            end
        end
        read_valid[lo] = 1'b0;
        wait_ready(lo, OP_READ, 1'b0);
        wait_ready(hi, OP_READ, 1'b1);
        if (read_data[hi] !== ref_mem[hi_addr]) begin
            report_value("read_data", 32'(read_data[hi]), 32'(ref_mem[hi_addr]));
        end
        read_valid[hi] = 1'b0;
        wait_ready(hi, OP_READ, 1'b0);
        if (mem_reads != base_reads) begin
            report_value("mem_read strobes", mem_reads - base_reads, 0);
        end
        end_test($sformatf("consumers %0d and %0d together", lo, hi), start_errors);
    endtask

    initial begin
        int cnt;
        int start_errors;
        errors = 0;
        tests = 0;
        failed_tests = 0;
        read_valid = '0;
        write_valid = '0;
        for (int i = 0; i < NUM_CONSUMERS; i++) begin
            read_address[i] = '0;
            write_address[i] = '0;
            write_data[i] = '0;
        end
        for (int a = 0; a < 256; a++) begin
            ref_mem[a] = word_t'(a) ^ 8'h5a;
        end

        // index 8 with tags 0 and 1 shares a line, 0x40 sits at index 0
        // no read repeats the word its consumer last saw, so stale read_data shows up
        add_row(2'd0, OP_READ, 8'h10, 8'h00, 2);
        add_row(2'd1, OP_READ, 8'h11, 8'h00, 0);
        add_row(2'd2, OP_READ, 8'h10, 8'h00, 0);
        add_row(2'd3, OP_WRITE, 8'h11, 8'ha5, 0);
        add_row(2'd0, OP_READ, 8'h11, 8'h00, 0);
        add_row(2'd1, OP_WRITE, 8'h40, 8'h3c, 0);
        add_row(2'd1, OP_READ, 8'h40, 8'h00, 2);
        add_row(2'd2, OP_READ, 8'h30, 8'h00, 2);
        add_row(2'd1, OP_READ, 8'h11, 8'h00, 2);
        add_row(2'd3, OP_READ, 8'h31, 8'h00, 2);
        add_row(2'd2, OP_READ, 8'hff, 8'h00, 2);
        add_row(2'd2, OP_READ, 8'hfe, 8'h00, 0);
        add_row(2'd0, OP_WRITE, 8'hfe, 8'h77, 0);
        add_row(2'd3, OP_READ, 8'hfe, 8'h00, 0);

        cnt = 0;
        while (reset !== 1'b0 && cnt < TIMEOUT_CYCLES) begin
            @(negedge clk);
            cnt++;
        end
        start_errors = errors;
        if (reset !== 1'b0) begin
            $display("timeout: reset was never released");
            errors++;
        end
        if (read_ready !== '0 || write_ready !== '0) begin
            report_value("ready bits", 32'({read_ready, write_ready}), 0);
        end
        if (mem_read_valid !== 1'b0 || mem_write_valid !== 1'b0) begin
            report_value("mem valids", 32'({mem_read_valid, mem_write_valid}), 0);
        end
        end_test("idle after reset", start_errors);

        for (int i = 0; i < rows.size(); i++) begin
            run_row(rows[i]);
        end
        // both lines still cached, no memory traffic expected
        serve_pair(2'd1, 8'hfe, 2'd3, 8'h40);

        $display("tests %0d, failed %0d, errors %0d", tests, failed_tests, errors);
        if (errors == 0) begin
            $display("Testbench passed");
        end else begin
            $display("Testbench failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- dmem_cache.f
design/dcache_geom_pkg.sv
design/dcache_ctrl_pkg.sv
design/consumer_arbiter.sv
design/cache_store.sv
design/mem_sequencer.sv
design/consumer_relay.sv
design/dmem_cache.sv
verif/tb_clock_gen.sv
verif/dmem_cache_asserts.sv
verif/dmem_cache_tb.sv

//--- Makefile
VERILATOR := verilator
VFLAGS    := --binary --timing --assert -j 0
TOP       := dmem_cache_tb
FILELIST  := dmem_cache.f
OBJ_DIR   := obj_dir
SIM       := $(OBJ_DIR)/V$(TOP)
SOURCES   := $(shell cat $(FILELIST))

.PHONY: all compile run clean

all: run

compile: $(SIM)

$(SIM): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

# pass only when the pass line shows up in the simulation output
run: compile
	@out="$$(./$(SIM))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "Testbench passed"

clean:
	rm -rf $(OBJ_DIR)
